/* verilog/axi_mem_settings.svh */
`ifndef AXI_MEM_SETTINGS_SVH
`define AXI_MEM_SETTINGS_SVH

// memory window as seen on the AXI bus
// byte address of word 0
`define AXI_MEM_BASE 32'h8000_0000

// ram depth in 64-bit words
`define AXI_MEM_WORDS 256

// bits in a word index, log2 of the depth
`define AXI_MEM_INDEX_BITS 8

// AXI response codes
// normal completion
`define AXI_RESP_OKAY 2'b00

// slave error, used for anything outside the window
`define AXI_RESP_SLVERR 2'b10

`endif

/* verilog/axi_mem_pkg.sv */
`default_nettype none

`include "axi_mem_settings.svh"

package axi_mem_pkg;

  // bus vectors
  typedef logic [31:0] axi_addr_t;
  typedef logic [63:0] axi_data_t;
  typedef logic [7:0]  axi_strb_t;
  // burst length minus one, up to 8 beats
  typedef logic [2:0]  axi_len_t;
  typedef logic [1:0]  axi_resp_t;

  // word index into the ram
  typedef logic [`AXI_MEM_INDEX_BITS-1:0] mem_index_t;

  // slave read side
  typedef enum logic [1:0] {
    slv_rd_idle,
    slv_rd_fetch,
    slv_rd_data
  } slv_rd_state_e;

  // slave write side
  typedef enum logic [1:0] {
    slv_wr_addr,
    slv_wr_data,
    slv_wr_resp
  } slv_wr_state_e;

  // master, one channel at a time
  typedef enum logic [2:0] {
    mst_idle,
    mst_ar,
    mst_r,
    mst_aw,
    mst_w,
    mst_b
  } mst_state_e;

endpackage

`default_nettype wire

/* verilog/mem_array.sv */
`default_nettype none

`include "axi_mem_settings.svh"

module mem_array (
  input  wire                          clock,
  input  wire                          en_i,
  input  wire                          we_i,
  input  wire axi_mem_pkg::mem_index_t index_i,
  input  wire axi_mem_pkg::axi_data_t  wdata_i,
  input  wire axi_mem_pkg::axi_strb_t  wstrb_i,
  output axi_mem_pkg::axi_data_t       rdata_o
);

  // word storage, contents undefined until written
  axi_mem_pkg::axi_data_t mem [`AXI_MEM_WORDS];

  // write side, one byte lane per strobe bit
  always_ff @(posedge clock) begin
    if (en_i && we_i) begin
      for (int b = 0; b < 8; b++) begin
        if (wstrb_i[b]) begin
          mem[index_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // read side
  // output register only loads on a read, so it holds across writes
  always_ff @(posedge clock) begin
    if (en_i && !we_i) begin
      rdata_o <= mem[index_i];
    end
  end

endmodule

`default_nettype wire

/* verilog/axi_mem_slave.sv */
`default_nettype none

`include "axi_mem_settings.svh"

module axi_mem_slave (
  input  wire                          clock,
  input  wire                          reset_n,
  // read address
  input  wire                          arvalid_i,
  input  wire axi_mem_pkg::axi_addr_t  araddr_i,
  input  wire axi_mem_pkg::axi_len_t   arlen_i,
  output logic                         arready_o,
  // read data
  input  wire                          rready_i,
  output logic                         rvalid_o,
  output axi_mem_pkg::axi_data_t       rdata_o,
  output axi_mem_pkg::axi_resp_t       rresp_o,
  output logic                         rlast_o,
  // write address
  input  wire                          awvalid_i,
  input  wire axi_mem_pkg::axi_addr_t  awaddr_i,
  output logic                         awready_o,
  // write data
  input  wire                          wvalid_i,
  input  wire axi_mem_pkg::axi_data_t  wdata_i,
  input  wire axi_mem_pkg::axi_strb_t  wstrb_i,
  input  wire                          wlast_i,
  output logic                         wready_o,
  // write response
  input  wire                          bready_i,
  output logic                         bvalid_o,
  output axi_mem_pkg::axi_resp_t       bresp_o,
  // ram port
  output logic                         mem_en_o,
  output logic                         mem_we_o,
  output axi_mem_pkg::mem_index_t      mem_index_o,
  output axi_mem_pkg::axi_data_t       mem_wdata_o,
  output axi_mem_pkg::axi_strb_t       mem_wstrb_o,
  input  wire axi_mem_pkg::axi_data_t  mem_rdata_i
);

  // window bounds in bytes
  localparam axi_mem_pkg::axi_addr_t win_base  = `AXI_MEM_BASE;
  localparam axi_mem_pkg::axi_addr_t win_bytes = `AXI_MEM_WORDS * 8;

  // true when the byte address hits the ram
  function automatic logic in_window(input axi_mem_pkg::axi_addr_t addr);
    axi_mem_pkg::axi_addr_t offset;
    offset = addr - win_base;
    return (addr >= win_base) && (offset < win_bytes);
  endfunction

  // word index inside the window, low 3 bits dropped
  function automatic axi_mem_pkg::mem_index_t word_index(input axi_mem_pkg::axi_addr_t addr);
    axi_mem_pkg::axi_addr_t offset;
    offset = addr - win_base;
    return offset[`AXI_MEM_INDEX_BITS+2:3];
  endfunction

  axi_mem_pkg::slv_rd_state_e rd_state;
  axi_mem_pkg::slv_wr_state_e wr_state;

  // latched request fields
  axi_mem_pkg::axi_addr_t rd_addr;
  axi_mem_pkg::axi_len_t  rd_len;
  axi_mem_pkg::axi_len_t  rd_beat;
  axi_mem_pkg::axi_addr_t rd_cur_addr;
  axi_mem_pkg::axi_addr_t wr_addr;

  logic ar_hs;
  logic r_hs;
  logic aw_hs;
  logic w_hs;
  logic b_hs;
  logic rd_in_win;
  logic rd_last;
  logic wr_in_win;
  logic wr_mem_use;
  logic rd_mem_use;
  logic rd_stall;

  assign ar_hs = arvalid_i && arready_o;
  assign r_hs  = rvalid_o && rready_i;
  assign aw_hs = awvalid_i && awready_o;
  assign w_hs  = wvalid_i && wready_o;
  assign b_hs  = bvalid_o && bready_i;

  // current beat address, 8 bytes per beat
  assign rd_cur_addr = rd_addr + axi_mem_pkg::axi_addr_t'({rd_beat, 3'b000});
  // window checked per beat, a burst can run off the end
  assign rd_in_win   = in_window(rd_cur_addr);
  assign rd_last     = (rd_beat == rd_len);
  assign wr_in_win   = in_window(wr_addr);

  // write owns the ram on its W handshake, read fetch waits a cycle
  assign wr_mem_use = w_hs && wr_in_win;
  assign rd_stall   = rd_in_win && wr_mem_use;
  assign rd_mem_use = (rd_state == axi_mem_pkg::slv_rd_fetch) && rd_in_win && !wr_mem_use;

  // ram port mux
  assign mem_en_o    = wr_mem_use || rd_mem_use;
  assign mem_we_o    = wr_mem_use;
  assign mem_index_o = wr_mem_use ? word_index(wr_addr) : word_index(rd_cur_addr);
  assign mem_wdata_o = wdata_i;
  assign mem_wstrb_o = wstrb_i;

  // read address and length, captured at AR
  always_ff @(posedge clock) begin
    if (ar_hs) begin
      rd_addr <= araddr_i;
      rd_len  <= arlen_i;
    end
  end

  // read burst FSM
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      rd_state <= axi_mem_pkg::slv_rd_idle;
      rd_beat  <= '0;
    end else begin
      case (rd_state)
        axi_mem_pkg::slv_rd_idle: begin
          if (ar_hs) begin
            rd_beat  <= '0;
            rd_state <= axi_mem_pkg::slv_rd_fetch;
          end
        end
        axi_mem_pkg::slv_rd_fetch: begin
          if (!rd_stall) begin
            rd_state <= axi_mem_pkg::slv_rd_data;
          end
        end
        axi_mem_pkg::slv_rd_data: begin
          // next beat refetches, last beat frees the channel
          if (r_hs && rd_last) begin
            rd_state <= axi_mem_pkg::slv_rd_idle;
          end else if (r_hs) begin
            rd_beat  <= rd_beat + 3'd1;
            rd_state <= axi_mem_pkg::slv_rd_fetch;
          end
        end
        default: rd_state <= axi_mem_pkg::slv_rd_idle;
      endcase
    end
  end

  // read outputs, ram register holds while rready is low
  assign arready_o = (rd_state == axi_mem_pkg::slv_rd_idle);
  assign rvalid_o  = (rd_state == axi_mem_pkg::slv_rd_data);
  assign rlast_o   = rvalid_o && rd_last;
  assign rresp_o   = rd_in_win ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
  assign rdata_o   = rd_in_win ? mem_rdata_i : '0;

  // write address, captured at AW
  always_ff @(posedge clock) begin
    if (aw_hs) begin
      wr_addr <= awaddr_i;
    end
  end

  // write FSM
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      wr_state <= axi_mem_pkg::slv_wr_addr;
    end else begin
      case (wr_state)
        axi_mem_pkg::slv_wr_addr: begin
          if (aw_hs) begin
            wr_state <= axi_mem_pkg::slv_wr_data;
          end
        end
        axi_mem_pkg::slv_wr_data: begin
          // stays for more beats until wlast
          if (w_hs && wlast_i) begin
            wr_state <= axi_mem_pkg::slv_wr_resp;
          end
        end
        axi_mem_pkg::slv_wr_resp: begin
          if (b_hs) begin
            wr_state <= axi_mem_pkg::slv_wr_addr;
          end
        end
        default: wr_state <= axi_mem_pkg::slv_wr_addr;
      endcase
    end
  end

  // write outputs
  assign awready_o = (wr_state == axi_mem_pkg::slv_wr_addr);
  assign wready_o  = (wr_state == axi_mem_pkg::slv_wr_data);
  assign bvalid_o  = (wr_state == axi_mem_pkg::slv_wr_resp);
  assign bresp_o   = wr_in_win ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;

endmodule

`default_nettype wire

/* verilog/lsu_axi_master.sv */
`default_nettype none

`include "axi_mem_settings.svh"

module lsu_axi_master (
  input  wire                          clock,
  input  wire                          reset_n,
  // core request
  input  wire                          start_i,
  input  wire                          write_i,
  input  wire axi_mem_pkg::axi_addr_t  addr_i,
  input  wire axi_mem_pkg::axi_len_t   len_i,
  input  wire axi_mem_pkg::axi_data_t  wdata_i,
  input  wire axi_mem_pkg::axi_strb_t  wstrb_i,
  input  wire                          rdata_ready_i,
  // core status and load data
  output logic                         busy_o,
  output logic                         done_o,
  output logic                         err_o,
  output logic                         rdata_valid_o,
  output axi_mem_pkg::axi_data_t       rdata_o,
  output logic                         rdata_last_o,
  // read address
  output logic                         arvalid_o,
  output axi_mem_pkg::axi_addr_t       araddr_o,
  output axi_mem_pkg::axi_len_t        arlen_o,
  input  wire                          arready_i,
  // read data
  output logic                         rready_o,
  input  wire                          rvalid_i,
  input  wire axi_mem_pkg::axi_data_t  rdata_i,
  input  wire axi_mem_pkg::axi_resp_t  rresp_i,
  input  wire                          rlast_i,
  // write address
  output logic                         awvalid_o,
  output axi_mem_pkg::axi_addr_t       awaddr_o,
  input  wire                          awready_i,
  // write data
  output logic                         wvalid_o,
  output axi_mem_pkg::axi_data_t       wdata_o,
  output axi_mem_pkg::axi_strb_t       wstrb_o,
  output logic                         wlast_o,
  input  wire                          wready_i,
  // write response
  output logic                         bready_o,
  input  wire                          bvalid_i,
  input  wire axi_mem_pkg::axi_resp_t  bresp_i
);

  axi_mem_pkg::mst_state_e state;

  // request held for the whole transaction
  axi_mem_pkg::axi_addr_t req_addr;
  axi_mem_pkg::axi_len_t  req_len;
  axi_mem_pkg::axi_data_t req_wdata;
  axi_mem_pkg::axi_strb_t req_wstrb;

  // sticky error over all beats
  logic err_acc;
  logic start_ok;
  logic r_hs;
  logic r_err;
  logic b_hs;
  logic b_err;

  assign start_ok = start_i && (state == axi_mem_pkg::mst_idle);
  assign r_hs     = rvalid_i && rready_o;
  assign r_err    = (rresp_i != `AXI_RESP_OKAY);
  assign b_hs     = bvalid_i && bready_o;
  assign b_err    = (bresp_i != `AXI_RESP_OKAY);

  // request capture on accepted start
  always_ff @(posedge clock) begin
    if (start_ok) begin
      req_addr  <= addr_i;
      req_len   <= len_i;
      req_wdata <= wdata_i;
      req_wstrb <= wstrb_i;
    end
  end

  // channel sequencing, one channel active at a time
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      state   <= axi_mem_pkg::mst_idle;
      err_acc <= 1'b0;
      done_o  <= 1'b0;
      err_o   <= 1'b0;
    end else begin
      // done and err are single-cycle
      done_o <= 1'b0;
      err_o  <= 1'b0;
      case (state)
        axi_mem_pkg::mst_idle: begin
          if (start_ok) begin
            err_acc <= 1'b0;
            state   <= write_i ? axi_mem_pkg::mst_aw : axi_mem_pkg::mst_ar;
          end
        end
        axi_mem_pkg::mst_ar: begin
          if (arready_i) state <= axi_mem_pkg::mst_r;
        end
        axi_mem_pkg::mst_r: begin
          if (r_hs) begin
            err_acc <= err_acc || r_err;
            if (rlast_i) begin
              done_o <= 1'b1;
              err_o  <= err_acc || r_err;
              state  <= axi_mem_pkg::mst_idle;
            end
          end
        end
        axi_mem_pkg::mst_aw: begin
          // W only after AW has gone
          if (awready_i) state <= axi_mem_pkg::mst_w;
        end
        axi_mem_pkg::mst_w: begin
          if (wready_i) state <= axi_mem_pkg::mst_b;
        end
        axi_mem_pkg::mst_b: begin
          if (b_hs) begin
            done_o <= 1'b1;
            err_o  <= err_acc || b_err;
            state  <= axi_mem_pkg::mst_idle;
          end
        end
        default: state <= axi_mem_pkg::mst_idle;
      endcase
    end
  end

  assign busy_o = (state != axi_mem_pkg::mst_idle);

  // AXI drive, valids straight from state so they hold until taken
  assign arvalid_o = (state == axi_mem_pkg::mst_ar);
  assign araddr_o  = req_addr;
  assign arlen_o   = req_len;
  assign awvalid_o = (state == axi_mem_pkg::mst_aw);
  assign awaddr_o  = req_addr;
  assign wvalid_o  = (state == axi_mem_pkg::mst_w);
  assign wdata_o   = req_wdata;
  assign wstrb_o   = req_wstrb;
  // single-beat writes
  assign wlast_o   = 1'b1;
  assign bready_o  = (state == axi_mem_pkg::mst_b);

  // read beats pass through, core back-pressure becomes rready
  assign rready_o      = (state == axi_mem_pkg::mst_r) && rdata_ready_i;
  assign rdata_valid_o = (state == axi_mem_pkg::mst_r) && rvalid_i;
  assign rdata_o       = rdata_i;
  assign rdata_last_o  = rdata_valid_o && rlast_i;

endmodule

`default_nettype wire

/* verilog/axi_mem_top.sv */
`default_nettype none

module axi_mem_top (
  input  wire                          clock,
  input  wire                          reset_n,
  input  wire                          start_i,
  input  wire                          write_i,
  input  wire axi_mem_pkg::axi_addr_t  addr_i,
  input  wire axi_mem_pkg::axi_len_t   len_i,
  input  wire axi_mem_pkg::axi_data_t  wdata_i,
  input  wire axi_mem_pkg::axi_strb_t  wstrb_i,
  input  wire                          rdata_ready_i,
  output logic                         busy_o,
  output logic                         done_o,
  output logic                         err_o,
  output logic                         rdata_valid_o,
  output axi_mem_pkg::axi_data_t       rdata_o,
  output logic                         rdata_last_o
);

  // AR and R
  logic                   arvalid;
  logic                   arready;
  axi_mem_pkg::axi_addr_t araddr;
  axi_mem_pkg::axi_len_t  arlen;
  logic                   rvalid;
  logic                   rready;
  axi_mem_pkg::axi_data_t rdata;
  axi_mem_pkg::axi_resp_t rresp;
  logic                   rlast;
  // AW, W and B
  logic                   awvalid;
  logic                   awready;
  axi_mem_pkg::axi_addr_t awaddr;
  logic                   wvalid;
  logic                   wready;
  axi_mem_pkg::axi_data_t wdata;
  axi_mem_pkg::axi_strb_t wstrb;
  logic                   wlast;
  logic                   bvalid;
  logic                   bready;
  axi_mem_pkg::axi_resp_t bresp;
  // ram port
  logic                    mem_en;
  logic                    mem_we;
  axi_mem_pkg::mem_index_t mem_index;
  axi_mem_pkg::axi_data_t  mem_wdata;
  axi_mem_pkg::axi_strb_t  mem_wstrb;
  axi_mem_pkg::axi_data_t  mem_rdata;

  // core side bridge
  lsu_axi_master master0 (
    .clock, .reset_n,
    .start_i, .write_i, .addr_i, .len_i, .wdata_i, .wstrb_i, .rdata_ready_i,
    .busy_o, .done_o, .err_o, .rdata_valid_o, .rdata_o, .rdata_last_o,
    .arvalid_o(arvalid), .araddr_o(araddr), .arlen_o(arlen), .arready_i(arready),
    .rready_o(rready), .rvalid_i(rvalid), .rdata_i(rdata), .rresp_i(rresp), .rlast_i(rlast),
    .awvalid_o(awvalid), .awaddr_o(awaddr), .awready_i(awready),
    .wvalid_o(wvalid), .wdata_o(wdata), .wstrb_o(wstrb), .wlast_o(wlast), .wready_i(wready),
    .bready_o(bready), .bvalid_i(bvalid), .bresp_i(bresp)
  );

  // memory side
  axi_mem_slave slave0 (
    .clock, .reset_n,
    .arvalid_i(arvalid), .araddr_i(araddr), .arlen_i(arlen), .arready_o(arready),
    .rready_i(rready), .rvalid_o(rvalid), .rdata_o(rdata), .rresp_o(rresp), .rlast_o(rlast),
    .awvalid_i(awvalid), .awaddr_i(awaddr), .awready_o(awready),
    .wvalid_i(wvalid), .wdata_i(wdata), .wstrb_i(wstrb), .wlast_i(wlast), .wready_o(wready),
    .bready_i(bready), .bvalid_o(bvalid), .bresp_o(bresp),
    .mem_en_o(mem_en), .mem_we_o(mem_we), .mem_index_o(mem_index),
    .mem_wdata_o(mem_wdata), .mem_wstrb_o(mem_wstrb), .mem_rdata_i(mem_rdata)
  );

  // storage
  mem_array ram0 (
    .clock,
    .en_i(mem_en), .we_i(mem_we), .index_i(mem_index),
    .wdata_i(mem_wdata), .wstrb_i(mem_wstrb), .rdata_o(mem_rdata)
  );

endmodule

`default_nettype wire

/* tests/axi_mem_tb.sv */
`default_nettype none

`include "axi_mem_settings.svh"

module axi_mem_tb;

  // transaction budget for the watchdog
  localparam int burst_txns = 12;
  localparam int sweep_txns = `AXI_MEM_WORDS / 8;
  localparam int txn_count  = `AXI_MEM_WORDS + burst_txns + sweep_txns + 13;

  logic                   clock;
  logic                   reset_n;
  logic                   start;
  logic                   is_write;
  axi_mem_pkg::axi_addr_t addr;
  axi_mem_pkg::axi_len_t  len;
  axi_mem_pkg::axi_data_t wdata;
  axi_mem_pkg::axi_strb_t wstrb;
  logic                   rdata_ready;
  logic                   busy;
  logic                   done;
  logic                   err;
  logic                   rdata_valid;
  axi_mem_pkg::axi_data_t rdata;
  logic                   rdata_last;

  // reference copy of the ram
  logic [63:0] model_mem [`AXI_MEM_WORDS];
  logic [31:0] rng = 32'hd2a2_e40e;

  axi_mem_top dut0 (
    .clock(clock), .reset_n(reset_n),
    .start_i(start), .write_i(is_write), .addr_i(addr), .len_i(len),
    .wdata_i(wdata), .wstrb_i(wstrb), .rdata_ready_i(rdata_ready),
    .busy_o(busy), .done_o(done), .err_o(err),
    .rdata_valid_o(rdata_valid), .rdata_o(rdata), .rdata_last_o(rdata_last)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // xorshift32
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [63:0] rand_data();
    return {next_rand(), next_rand()};
  endfunction

  // aligned word somewhere in the window
  function automatic logic [31:0] rand_addr();
    logic [31:0] r;
    r = next_rand();
    return `AXI_MEM_BASE + 8 * (r % `AXI_MEM_WORDS);
  endfunction

  function automatic logic in_window(input logic [31:0] a);
    return (a >= `AXI_MEM_BASE) && (a < `AXI_MEM_BASE + 8 * `AXI_MEM_WORDS);
  endfunction

  // model slot of an in-window byte address, 8 bytes per word
  function automatic int word_of(input logic [31:0] a);
    return int'((a - `AXI_MEM_BASE) / 8);
  endfunction

  // new bytes in the strobed lanes and old bytes elsewhere
  function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
                                              input logic [63:0] new_word,
                                              input logic [7:0] strb);
    logic [63:0] res;
    res = old_word;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) res[b*8 +: 8] = new_word[b*8 +: 8];
    end
    return res;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("ERROR: %s", what);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  // one core request with each beat checked as it is taken
  // bp randomizes rdata_ready
  // poke fires a second start while busy
  task automatic transact(input string name, input logic wr, input logic [31:0] a,
                          input logic [2:0] n, input logic [63:0] d, input logic [7:0] s,
                          input logic bp, input logic poke);
    int beats;
    int cyc;
    logic held;
    logic ready;
    logic exp_err;
    logic [31:0] r;
    logic [31:0] beat_addr;
    logic [63:0] held_data;
    logic [63:0] exp_data;
    beats = 0;
    cyc = 0;
    held = 1'b0;
    start = 1'b1;
    is_write = wr;
    addr = a;
    len = n;
    wdata = d;
    wstrb = s;
    @(negedge clock);
    start = 1'b0;
    while (!done) begin
      if (cyc == 0) check_true(busy, {name, ": busy_o low after accepted start"});
      // conflicting write to the same word that must be dropped
      if (poke && cyc == 0) begin
        start = 1'b1;
        is_write = 1'b1;
        wdata = ~d;
        wstrb = 8'hff;
      end else begin
        start = 1'b0;
      end
      // stalled beat has to stay put
      if (held) begin
        check_true(rdata_valid, {name, ": rdata_valid_o dropped while stalled"});
        check_value({name, " stalled rdata"}, held_data, rdata);
      end
      r = next_rand();
      ready = bp ? r[0] : 1'b1;
      held = 1'b0;
      if (rdata_valid && ready) begin
        check_true(beats <= int'(n), {name, ": more read beats than requested"});
        beat_addr = a + 8 * beats;
        exp_data = in_window(beat_addr) ? model_mem[word_of(beat_addr)] : 64'h0;
        check_value({name, " rdata"}, exp_data, rdata);
        check_value({name, " rdata_last"}, beats == int'(n), rdata_last);
        beats++;
      end else if (rdata_valid) begin
        held = 1'b1;
        held_data = rdata;
      end
      rdata_ready = ready;
      cyc++;
      @(negedge clock);
    end
    start = 1'b0;
    // error if any beat leaves the window
    exp_err = !in_window(a);
    if (!wr) begin
      for (int i = 1; i <= int'(n); i++) begin
        if (!in_window(a + 8 * i)) exp_err = 1'b1;
      end
      check_value({name, " beat count"}, int'(n) + 1, beats);
    end
    check_value({name, " err_o"}, exp_err, err);
    if (wr && in_window(a)) model_mem[word_of(a)] = merge_bytes(model_mem[word_of(a)], d, s);
    if (poke) begin
      repeat (5) begin
        @(negedge clock);
        check_true(!done && !busy, {name, ": ignored start produced a transaction"});
      end
    end
  endtask

  // watchdog allows 40 cycles per transaction plus reset
  initial begin
    #((txn_count * 40 + 20) * 40);
    $display("ERROR: timeout, a transaction never reported done_o");
    $display("Testbench failed");
    $fatal(1);
  end

  initial begin
    logic [31:0] a;
    logic [31:0] r;
    logic [63:0] d1;
    logic [63:0] d2;
    logic [2:0] n;
    start = 1'b0;
    is_write = 1'b0;
    addr = '0;
    len = '0;
    wdata = '0;
    wstrb = '0;
    rdata_ready = 1'b1;
    reset_n = 1'b0;
    repeat (10) @(negedge clock);
    reset_n = 1'b1;
    @(negedge clock);
    check_value("reset outputs", 5'b0, {busy, done, err, rdata_valid, rdata_last});

    // known contents everywhere
    for (int i = 0; i < `AXI_MEM_WORDS; i++) begin
      transact("fill write", 1'b1, `AXI_MEM_BASE + 8 * i, 3'd0, rand_data(), 8'hff, 1'b0, 1'b0);
    end

    a = rand_addr();
    transact("round trip write", 1'b1, a, 3'd0, rand_data(), 8'hff, 1'b0, 1'b0);
    transact("round trip read", 1'b0, a, 3'd0, 64'h0, 8'h0, 1'b0, 1'b0);

    a = rand_addr();
    d1 = rand_data();
    d2 = rand_data();
    r = next_rand();
    transact("merge first write", 1'b1, a, 3'd0, d1, 8'hff, 1'b0, 1'b0);
    transact("merge strobed write", 1'b1, a, 3'd0, d2, r[7:0], 1'b0, 1'b0);
    transact("merge read", 1'b0, a, 3'd0, 64'h0, 8'h0, 1'b0, 1'b0);

    // every length first and then random ones
    for (int i = 0; i < burst_txns; i++) begin
      r = next_rand();
      n = (i < 8) ? 3'(i) : r[2:0];
      a = `AXI_MEM_BASE + 8 * (next_rand() % (`AXI_MEM_WORDS - 7));
      transact("burst read", 1'b0, a, n, 64'h0, 8'h0, 1'b1, 1'b0);
    end

    // outside the window
    transact("read below window", 1'b0, `AXI_MEM_BASE - 32'h100, 3'd2, 64'h0, 8'h0, 1'b1, 1'b0);
    transact("read above window", 1'b0, `AXI_MEM_BASE + 8 * `AXI_MEM_WORDS, 3'd3,
             64'h0, 8'h0, 1'b1, 1'b0);
    transact("read across window end", 1'b0, `AXI_MEM_BASE + 8 * (`AXI_MEM_WORDS - 3), 3'd7,
             64'h0, 8'h0, 1'b1, 1'b0);
    transact("write below window", 1'b1, `AXI_MEM_BASE - 8, 3'd0, rand_data(), 8'hff,
             1'b0, 1'b0);
    transact("write above window", 1'b1, `AXI_MEM_BASE + 8 * `AXI_MEM_WORDS + 32'h40, 3'd0,
             rand_data(), 8'hff, 1'b0, 1'b0);

    // second start during a write and during a read
    a = rand_addr();
    transact("busy write", 1'b1, a, 3'd0, rand_data(), 8'hff, 1'b0, 1'b1);
    transact("busy read", 1'b0, a, 3'd0, 64'h0, 8'h0, 1'b1, 1'b1);
    transact("busy check read", 1'b0, a, 3'd0, 64'h0, 8'h0, 1'b0, 1'b0);

    // whole ram against the model
    for (int i = 0; i < sweep_txns; i++) begin
      transact("sweep read", 1'b0, `AXI_MEM_BASE + 64 * i, 3'd7, 64'h0, 8'h0, 1'b1, 1'b0);
    end

    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+verilog
verilog/axi_mem_pkg.sv
verilog/mem_array.sv
verilog/axi_mem_slave.sv
verilog/lsu_axi_master.sv
verilog/axi_mem_top.sv
tests/axi_mem_tb.sv

/* Bender.yml */
package:
  name: axi_mem

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/axi_mem_pkg.sv
      - verilog/mem_array.sv
      - verilog/axi_mem_slave.sv
      - verilog/lsu_axi_master.sv
      - verilog/axi_mem_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/axi_mem_tb.sv
